//--- verilog/alu_pkg.sv
`default_nettype none

package alu_pkg;

    // operation select for the 32-bit ALU.
    typedef enum logic [2:0] {
        ALU_OP_ADD,
        ALU_OP_SUB,
        ALU_OP_AND,
        ALU_OP_OR,
        ALU_OP_SLT
    } alu_op_e;

    // bit positions inside the 4-bit flag vector.
    localparam int alu_flag_zero  = 0;
    localparam int alu_flag_neg   = 1;
    localparam int alu_flag_carry = 2;
    localparam int alu_flag_ovf   = 3;

endpackage

`default_nettype wire

//--- verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = '0;

    // supported major opcodes.
    typedef enum logic [6:0] {
        OP_I_TYPE_L   = 7'b0000011,
        OP_I_TYPE_ALU = 7'b0010011,
        OP_S_TYPE     = 7'b0100011,
        OP_R_TYPE     = 7'b0110011,
        OP_B_TYPE     = 7'b1100011
    } op_e;

    localparam logic [2:0] funct3_add = 3'b000; // add, sub, addi.
    localparam logic [2:0] funct3_slt = 3'b010;
    localparam logic [2:0] funct3_or  = 3'b110;
    localparam logic [2:0] funct3_and = 3'b111;
    localparam logic [6:0] funct7_alt = 7'b0100000; // selects sub.

    // operand select; a and b each use their own three codes.
    typedef logic [1:0] alu_src_e;

    localparam alu_src_e ALU_SRC_PC      = 2'd0;
    localparam alu_src_e ALU_SRC_OLD_PC  = 2'd1;
    localparam alu_src_e ALU_SRC_REG_1   = 2'd2;

    localparam alu_src_e ALU_SRC_REG_2   = 2'd0;
    localparam alu_src_e ALU_SRC_EXT_IMM = 2'd1;
    localparam alu_src_e ALU_SRC_4       = 2'd2;

    typedef enum logic [1:0] {
        RES_SRC_ALU_OUT,
        RES_SRC_MEM,
        RES_SRC_ALU_RESULT
    } res_src_e;

    typedef enum logic [1:0] {
        IMM_SRC_NONE,
        IMM_SRC_ITYPE,
        IMM_SRC_STYPE,
        IMM_SRC_BTYPE
    } imm_src_e;

    typedef enum logic [3:0] {
        FETCH,
        DECODE,
        MEM_ADDR,
        MEM_READ,
        MEM_WRITE,
        RF_WRITE,
        EXECUTE_R,
        EXECUTE_I,
        ALU_WB,
        BRANCH
    } rv_mcyc_st_e;

endpackage

`default_nettype wire

//--- verilog/alu.sv
`default_nettype none

module alu (
    input  wire [rv_pkg::xlen-1:0]  a,
    input  wire [rv_pkg::xlen-1:0]  b,
    input  wire alu_pkg::alu_op_e   op,
    output logic [rv_pkg::xlen-1:0] result,
    output logic [3:0]              flags
);
    import rv_pkg::*;
    import alu_pkg::*;

    logic            is_sub;
    logic            is_arith;
    logic [xlen-1:0] b_in;
    logic [xlen:0]   sum;
    logic            ovf;
    logic            lt;

    assign is_sub   = (op == ALU_OP_SUB) || (op == ALU_OP_SLT);
    assign is_arith = (op == ALU_OP_ADD) || (op == ALU_OP_SUB);
    assign b_in     = is_sub ? ~b : b;
    assign sum      = {1'b0, a} + {1'b0, b_in} + {{xlen{1'b0}}, is_sub};

    // signed overflow when operands agree in sign and the sum does not.
    assign ovf = (a[xlen-1] == b_in[xlen-1]) && (sum[xlen-1] != a[xlen-1]);
    assign lt  = sum[xlen-1] ^ ovf;

    always_comb begin
        case (op)
            ALU_OP_AND: result = a & b;
            ALU_OP_OR:  result = a | b;
            ALU_OP_SLT: result = {{(xlen-1){1'b0}}, lt};
            default:    result = sum[xlen-1:0];
        endcase
    end

    always_comb begin
        flags                 = '0;
        flags[alu_flag_zero]  = (result == '0);
        flags[alu_flag_neg]   = result[xlen-1];
        flags[alu_flag_carry] = is_arith & sum[xlen];
        flags[alu_flag_ovf]   = is_arith & ovf;
    end

endmodule

`default_nettype wire

//--- verilog/imm_extend.sv
`default_nettype none

module imm_extend (
    input  wire [31:0]                  instr,
    input  wire rv_pkg::imm_src_e       imm_src,
    output logic [rv_pkg::xlen-1:0]     imm_ext
);
    import rv_pkg::*;

    always_comb begin
        case (imm_src)
            IMM_SRC_ITYPE: begin
                imm_ext = {{(xlen-12){instr[31]}}, instr[31:20]};
            end
            IMM_SRC_STYPE: begin
                imm_ext = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
            end
            IMM_SRC_BTYPE: begin
                // offset in halfwords, bit 0 always zero.
                imm_ext = {{(xlen-12){instr[31]}}, instr[7], instr[30:25],
                           instr[11:8], 1'b0};
            end
            default: imm_ext = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`default_nettype none

module reg_file (
    input  wire                     clk,
    input  wire [4:0]               a1,
    input  wire [4:0]               a2,
    input  wire [4:0]               a3,
    input  wire [rv_pkg::xlen-1:0]  wd3,
    input  wire                     we3,
    output wire [rv_pkg::xlen-1:0]  rd1,
    output wire [rv_pkg::xlen-1:0]  rd2
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [32];

    // x0 never stored.
    always_ff @(posedge clk) begin
        if (we3 && a3 != 5'd0) begin
            regs[a3] <= wd3;
        end
    end

    assign rd1 = (a1 == 5'd0) ? '0 : regs[a1];
    assign rd2 = (a2 == 5'd0) ? '0 : regs[a2];

endmodule

`default_nettype wire

//--- verilog/controller_multicycle.sv
`default_nettype none

module controller_multicycle (
    input  wire [31:0]          instr,
    input  wire [3:0]           alu_flags,
    input  wire                 clk,
    input  wire                 rst,
    output logic                rf_we,
    output logic                m_we,
    output logic                pc_we,
    output logic                en_ir,
    output logic                en_npc_r,
    output logic                m_addr_src,
    output rv_pkg::alu_src_e    alu_src_a,
    output rv_pkg::alu_src_e    alu_src_b,
    output rv_pkg::res_src_e    res_src,
    output rv_pkg::imm_src_e    imm_src,
    output alu_pkg::alu_op_e    alu_ctrl
);
    import rv_pkg::*;
    import alu_pkg::*;

    op_e         op;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    rv_mcyc_st_e state;
    alu_op_e     alu_dec;

    assign op     = op_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= FETCH;
        end else begin
            case (state)
                FETCH:     state <= DECODE;
                DECODE: begin
                    case (op)
                        OP_I_TYPE_L, OP_S_TYPE: state <= MEM_ADDR;
                        OP_R_TYPE:              state <= EXECUTE_R;
                        OP_I_TYPE_ALU:          state <= EXECUTE_I;
                        OP_B_TYPE:              state <= BRANCH;
                        default:                state <= FETCH; // unsupported, skip.
                    endcase
                end
                MEM_ADDR:  state <= (op == OP_I_TYPE_L) ? MEM_READ : MEM_WRITE;
                MEM_READ:  state <= RF_WRITE;
                EXECUTE_R: state <= ALU_WB;
                EXECUTE_I: state <= ALU_WB;
                default:   state <= FETCH;
            endcase
        end
    end

    // funct decode, only sub needs funct7 and only for R-type.
    always_comb begin
        case (funct3)
            funct3_add: alu_dec = (op == OP_R_TYPE && funct7 == funct7_alt) ? ALU_OP_SUB
                                                                           : ALU_OP_ADD;
            funct3_slt: alu_dec = ALU_OP_SLT;
            funct3_or:  alu_dec = ALU_OP_OR;
            funct3_and: alu_dec = ALU_OP_AND;
            default:    alu_dec = ALU_OP_ADD;
        endcase
    end

    always_comb begin
        rf_we      = 1'b0;
        m_we       = 1'b0;
        pc_we      = 1'b0;
        en_ir      = 1'b0;
        en_npc_r   = 1'b0;
        m_addr_src = 1'b0;
        alu_src_a  = ALU_SRC_REG_1;
        alu_src_b  = ALU_SRC_EXT_IMM;
        res_src    = RES_SRC_ALU_OUT;
        imm_src    = IMM_SRC_NONE;
        alu_ctrl   = ALU_OP_ADD;
        case (state)
            FETCH: begin
                alu_src_a = ALU_SRC_PC; // pc + 4 into alu_out.
                alu_src_b = ALU_SRC_4;
                en_ir     = 1'b1;
            end
            DECODE: begin
                alu_src_a = ALU_SRC_OLD_PC; // branch target.
                imm_src   = IMM_SRC_BTYPE;
                en_npc_r  = 1'b1;
                pc_we     = 1'b1;
            end
            MEM_ADDR:  imm_src = (op == OP_I_TYPE_L) ? IMM_SRC_ITYPE : IMM_SRC_STYPE;
            MEM_READ:  m_addr_src = 1'b1;
            MEM_WRITE: begin
                m_addr_src = 1'b1;
                m_we       = 1'b1;
            end
            RF_WRITE: begin
                res_src = RES_SRC_MEM;
                rf_we   = 1'b1;
            end
            EXECUTE_R: begin
                alu_src_b = ALU_SRC_REG_2;
                alu_ctrl  = alu_dec;
            end
            EXECUTE_I: begin
                imm_src  = IMM_SRC_ITYPE;
                alu_ctrl = alu_dec;
            end
            ALU_WB:    rf_we = 1'b1;
            BRANCH: begin
                alu_src_b = ALU_SRC_REG_2;
                alu_ctrl  = ALU_OP_SUB;
                pc_we     = alu_flags[alu_flag_zero]; // taken when rs1 == rs2.
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/datapath_multicycle.sv
`default_nettype none

module datapath_multicycle (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         rf_we,
    input  wire rv_pkg::alu_src_e       alu_src_a,
    input  wire rv_pkg::alu_src_e       alu_src_b,
    input  wire rv_pkg::res_src_e       res_src,
    input  wire rv_pkg::imm_src_e       imm_src,
    input  wire alu_pkg::alu_op_e       alu_ctrl,
    input  wire                         en_ir,
    input  wire                         en_npc_r,
    input  wire                         m_addr_src,
    input  wire                         pc_we,
    input  wire [rv_pkg::xlen-1:0]      mem_rdata,
    output wire [31:0]                  instr,
    output wire [3:0]                   alu_flags,
    output wire [rv_pkg::xlen-1:0]      mem_addr,
    output wire [rv_pkg::xlen-1:0]      mem_wdata
);
    import rv_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] old_pc;
    logic [31:0]     ir;
    logic [xlen-1:0] data_r;
    logic [xlen-1:0] a_r;
    logic [xlen-1:0] b_r;
    logic [xlen-1:0] alu_out;

    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    logic [xlen-1:0] imm_ext;
    logic [xlen-1:0] src_a;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] result;

    // ir and old_pc capture together, so old_pc holds the fetch address.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc     <= reset_pc;
            old_pc <= reset_pc;
            ir     <= '0;
        end else begin
            if (en_ir) begin
                ir     <= mem_rdata;
                old_pc <= pc;
            end
            if (pc_we) begin
                pc <= en_npc_r ? alu_out : result; // pc + 4 in decode.
            end
        end
    end

    always_ff @(posedge clk) begin
        data_r  <= mem_rdata;
        a_r     <= rd1;
        b_r     <= rd2;
        alu_out <= alu_result;
    end

    reg_file i_reg_file (
        .clk (clk),
        .a1  (ir[19:15]),
        .a2  (ir[24:20]),
        .a3  (ir[11:7]),
        .wd3 (result),
        .we3 (rf_we),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    imm_extend i_imm_extend (
        .instr   (ir),
        .imm_src (imm_src),
        .imm_ext (imm_ext)
    );

    always_comb begin
        case (alu_src_a)
            ALU_SRC_PC:     src_a = pc;
            ALU_SRC_OLD_PC: src_a = old_pc;
            ALU_SRC_REG_1:  src_a = a_r;
            default:        src_a = pc;
        endcase
    end

    always_comb begin
        case (alu_src_b)
            ALU_SRC_REG_2:   src_b = b_r;
            ALU_SRC_EXT_IMM: src_b = imm_ext;
            ALU_SRC_4:       src_b = xlen'(4);
            default:         src_b = b_r;
        endcase
    end

    alu i_alu (
        .a      (src_a),
        .b      (src_b),
        .op     (alu_ctrl),
        .result (alu_result),
        .flags  (alu_flags)
    );

    always_comb begin
        case (res_src)
            RES_SRC_MEM:        result = data_r;
            RES_SRC_ALU_RESULT: result = alu_result;
            default:            result = alu_out;
        endcase
    end

    assign mem_addr  = m_addr_src ? alu_out : pc;
    assign mem_wdata = b_r; // rs2 for sw.
    assign instr     = ir;

endmodule

`default_nettype wire

//--- verilog/rv_multicycle.sv
`default_nettype none

module rv_multicycle (
    input  wire                     clk,
    input  wire                     rst,
    output wire [rv_pkg::xlen-1:0]  mem_addr,
    output wire [rv_pkg::xlen-1:0]  mem_wdata,
    output wire                     mem_we,
    input  wire [rv_pkg::xlen-1:0]  mem_rdata
);
    import rv_pkg::*;
    import alu_pkg::*;

    wire [31:0] instr;
    wire [3:0]  alu_flags;
    wire        rf_we;
    wire        pc_we;
    wire        en_ir;
    wire        en_npc_r;
    wire        m_addr_src;
    alu_src_e   alu_src_a;
    alu_src_e   alu_src_b;
    res_src_e   res_src;
    imm_src_e   imm_src;
    alu_op_e    alu_ctrl;

    controller_multicycle i_controller_multicycle (
        .instr      (instr),
        .alu_flags  (alu_flags),
        .clk        (clk),
        .rst        (rst),
        .rf_we      (rf_we),
        .m_we       (mem_we),
        .pc_we      (pc_we),
        .en_ir      (en_ir),
        .en_npc_r   (en_npc_r),
        .m_addr_src (m_addr_src),
        .alu_src_a  (alu_src_a),
        .alu_src_b  (alu_src_b),
        .res_src    (res_src),
        .imm_src    (imm_src),
        .alu_ctrl   (alu_ctrl)
    );

    datapath_multicycle i_datapath_multicycle (
        .clk        (clk),
        .rst        (rst),
        .rf_we      (rf_we),
        .alu_src_a  (alu_src_a),
        .alu_src_b  (alu_src_b),
        .res_src    (res_src),
        .imm_src    (imm_src),
        .alu_ctrl   (alu_ctrl),
        .en_ir      (en_ir),
        .en_npc_r   (en_npc_r),
        .m_addr_src (m_addr_src),
        .pc_we      (pc_we),
        .mem_rdata  (mem_rdata),
        .instr      (instr),
        .alu_flags  (alu_flags),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

endmodule

`default_nettype wire

//--- test/rv_multicycle_chk.sv
`default_nettype none

module rv_multicycle_chk (
    input  wire                         clk,
    input  wire                         rst,
    input  wire rv_pkg::rv_mcyc_st_e    state,
    input  wire                         m_we,
    input  wire                         en_ir
);
    timeunit 1ns;
    timeprecision 100ps;
    import rv_pkg::*;

    // first cycle out of reset is a fetch.
    assert property (@(posedge clk) $fell(rst) |-> state == FETCH)
        else $error("controller is not in FETCH after reset");

    assert property (@(posedge clk) disable iff (rst) m_we |-> state == MEM_WRITE)
        else $error("m_we high outside MEM_WRITE");

    assert property (@(posedge clk) disable iff (rst) en_ir |-> state == FETCH)
        else $error("en_ir high outside FETCH");

    // address is formed one cycle before the write.
    assert property (@(posedge clk) disable iff (rst)
                     state == MEM_WRITE |-> $past(state) == MEM_ADDR)
        else $error("MEM_WRITE not preceded by MEM_ADDR");

endmodule

bind controller_multicycle rv_multicycle_chk i_rv_multicycle_chk (
    .clk   (clk),
    .rst   (rst),
    .state (state),
    .m_we  (m_we),
    .en_ir (en_ir)
);

`default_nettype wire

//--- test/rv_multicycle_tb.sv
`default_nettype none

module rv_multicycle_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_pkg::*;

    localparam int mem_words     = 256;
    localparam int clk_half      = 2;
    localparam int reset_cycles  = 16;
    localparam int margin_cycles = 64;

    // instruction kinds of the program table.
    localparam int k_lw   = 0;
    localparam int k_sw   = 1;
    localparam int k_addi = 2;
    localparam int k_add  = 3;
    localparam int k_sub  = 4;
    localparam int k_and  = 5;
    localparam int k_or   = 6;
    localparam int k_slt  = 7;
    localparam int k_beq  = 8;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        mem_we;

    logic [31:0] mem [mem_words];
    logic [31:0] ref_mem [mem_words];
    logic [31:0] ref_regs [32];
    int          kind_q[$];
    int          rd_q[$];
    int          rs1_q[$];
    int          rs2_q[$];
    int          imm_q[$];
    logic [31:0] exp_addr_q[$];
    logic [31:0] exp_data_q[$];
    logic [31:0] halt_addr;
    logic [31:0] rnd;
    int          store_count    = 0;
    int          value_errors   = 0;
    int          other_errors   = 0;
    int          timeout_cycles = 0;

    rv_multicycle i_rv_multicycle (
        .clk       (clk),
        .rst       (rst),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_rdata (mem_rdata)
    );

    // 1 KiB shared memory addressed by word.
    assign mem_rdata = mem[mem_addr[9:2]];

    always @(posedge clk) begin
        if (mem_we === 1'b1) begin
            mem[mem_addr[9:2]] <= mem_wdata;
        end
    end

    initial begin
        forever #clk_half clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] encode(input int kind, input int rd, input int rs1,
                                           input int rs2, input int imm);
        logic [31:0] im;
        logic [4:0]  d;
        logic [4:0]  s1;
        logic [4:0]  s2;
        logic [31:0] word;
        im = imm;
        d  = 5'(rd);
        s1 = 5'(rs1);
        s2 = 5'(rs2);
        case (kind)
            k_lw:    word = {im[11:0], s1, 3'b010, d, 7'b0000011};
            k_sw:    word = {im[11:5], s2, s1, 3'b010, im[4:0], 7'b0100011};
            k_addi:  word = {im[11:0], s1, 3'b000, d, 7'b0010011};
            k_add:   word = {7'b0000000, s2, s1, 3'b000, d, 7'b0110011};
            k_sub:   word = {7'b0100000, s2, s1, 3'b000, d, 7'b0110011};
            k_and:   word = {7'b0000000, s2, s1, 3'b111, d, 7'b0110011};
            k_or:    word = {7'b0000000, s2, s1, 3'b110, d, 7'b0110011};
            k_slt:   word = {7'b0000000, s2, s1, 3'b010, d, 7'b0110011};
            k_beq:   word = {im[12], im[10:5], s2, s1, 3'b000, im[4:1], im[11], 7'b1100011};
            default: word = 32'h0;
        endcase
        return word;
    endfunction

    task automatic add_instr(input int kind, input int rd, input int rs1, input int rs2,
                             input int imm);
        mem[kind_q.size()] = encode(kind, rd, rs1, rs2, imm);
        kind_q.push_back(kind);
        rd_q.push_back(rd);
        rs1_q.push_back(rs1);
        rs2_q.push_back(rs2);
        imm_q.push_back(imm);
    endtask

    // data sits at 0x200 and stores go around 0x340.
    task automatic load_program();
        add_instr(k_addi, 1, 0, 0, 512);
        add_instr(k_addi, 2, 0, 0, 832);
        add_instr(k_lw,   3, 1, 0, 0);
        add_instr(k_lw,   4, 1, 0, 4);
        add_instr(k_lw,   5, 1, 0, 8);
        add_instr(k_lw,  14, 1, 0, 60);
        add_instr(k_sw,   0, 2, 3, 0);
        add_instr(k_sw,   0, 2, 4, 4);
        add_instr(k_sw,   0, 2, 14, -8);
        add_instr(k_add,  6, 3, 4, 0);
        add_instr(k_sw,   0, 2, 6, 8);
        add_instr(k_sub,  7, 3, 4, 0);
        add_instr(k_sw,   0, 2, 7, 12);
        add_instr(k_and,  8, 3, 5, 0);
        add_instr(k_sw,   0, 2, 8, 16);
        add_instr(k_or,   9, 4, 5, 0);
        add_instr(k_sw,   0, 2, 9, 20);
        add_instr(k_slt, 10, 3, 4, 0);
        add_instr(k_sw,   0, 2, 10, 24);
        add_instr(k_slt, 11, 4, 3, 0);
        add_instr(k_sw,   0, 2, 11, 28);
        add_instr(k_addi, 12, 5, 0, -1000);
        add_instr(k_sw,   0, 2, 12, 32);
        add_instr(k_addi, 13, 14, 0, 1234);
        add_instr(k_sw,   0, 2, 13, 36);
        add_instr(k_beq,  0, 3, 3, 8);      // always taken.
        add_instr(k_sw,   0, 2, 6, 40);
        add_instr(k_beq,  0, 3, 4, 8);
        add_instr(k_sw,   0, 2, 7, 44);
        add_instr(k_addi, 0, 3, 0, 5);
        add_instr(k_add,  0, 3, 4, 0);
        add_instr(k_sw,   0, 2, 0, 48);
        add_instr(k_sub, 16, 0, 3, 0);      // opposite sign for slt.
        add_instr(k_slt, 17, 16, 3, 0);
        add_instr(k_sw,   0, 2, 17, 52);
        add_instr(k_beq,  0, 0, 0, 0);      // loops on itself.
    endtask

    // instruction level model over the table that collects expected stores.
    task automatic run_reference();
        int          i;
        int          pc_idx;
        int          steps;
        int          rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sum;
        for (i = 0; i < mem_words; i++) begin
            ref_mem[i] = mem[i];
        end
        for (i = 0; i < 32; i++) begin
            ref_regs[i] = 32'h0;
        end
        pc_idx = 0;
        steps  = 0;
        while (pc_idx < kind_q.size() - 1 && steps < 4 * kind_q.size()) begin
            rd  = rd_q[pc_idx];
            a   = ref_regs[rs1_q[pc_idx]];
            b   = ref_regs[rs2_q[pc_idx]];
            sum = a + imm_q[pc_idx];
            steps++;
            case (kind_q[pc_idx])
                k_lw:   ref_regs[rd] = ref_mem[sum[9:2]];
                k_sw: begin
                    ref_mem[sum[9:2]] = b;
                    exp_addr_q.push_back(sum);
                    exp_data_q.push_back(b);
                end
                k_addi: ref_regs[rd] = sum;
                k_add:  ref_regs[rd] = a + b;
                k_sub:  ref_regs[rd] = a - b;
                k_and:  ref_regs[rd] = a & b;
                k_or:   ref_regs[rd] = a | b;
                k_slt:  ref_regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default: ;
            endcase
            ref_regs[0] = 32'h0;
            if (kind_q[pc_idx] == k_beq && a == b) begin
                pc_idx += imm_q[pc_idx] / 4;
            end else begin
                pc_idx++;
            end
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error: %s = %h, expected %h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic print_summary();
        $display("stores seen %0d of %0d, value errors %0d, other errors %0d",
                 store_count, exp_addr_q.size(), value_errors, other_errors);
    endtask

    always @(negedge clk) begin
        if (rst) begin
            check("mem_we", {31'b0, mem_we}, 32'h0);
        end else if (mem_we !== 1'b0) begin
            if (store_count < exp_addr_q.size()) begin
                check("mem_addr", mem_addr, exp_addr_q[store_count]);
                check("mem_wdata", mem_wdata, exp_data_q[store_count]);
            end else begin
                other_errors++;
                $display("store strobe at %0t ns beyond the %0d expected stores",
                         $time, exp_addr_q.size());
            end
            store_count++;
        end
    end

    initial begin
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge clk);
        other_errors++;
        $display("timeout, final loop branch not reached within %0d cycles", timeout_cycles);
        print_summary();
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : main
        int i;
        rnd = 32'd2084;
        for (i = 0; i < mem_words; i++) begin
            rnd    = xorshift(rnd);
            mem[i] = rnd ^ (i << 2);
        end
        load_program();
        halt_addr = (kind_q.size() - 1) * 4;
        run_reference();
        timeout_cycles = reset_cycles + 5 * kind_q.size() + margin_cycles;

        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check("mem_addr", mem_addr, reset_pc); // first fetch.

        // pc passes the halt loop only while its branch resolves.
        while (mem_addr !== halt_addr + 32'd4) begin
            @(negedge clk);
        end
        check("store count", store_count, exp_addr_q.size());

        print_summary();
        if (value_errors + other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
verilog/alu_pkg.sv
verilog/rv_pkg.sv
verilog/alu.sv
verilog/imm_extend.sv
verilog/reg_file.sv
verilog/controller_multicycle.sv
verilog/datapath_multicycle.sv
verilog/rv_multicycle.sv
test/rv_multicycle_chk.sv
test/rv_multicycle_tb.sv
